/* include/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// rv32i base opcodes, ins[6:0]
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011
`define OPC_SYSTEM 7'b1110011

// alu selector codes seen by execute
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_XOR 3'd4
`define ALU_SLT 3'd5
`define ALU_SLL 3'd6
`define ALU_SRL 3'd7

// branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// system words, matched in full
`define INS_ECALL 32'h0000_0073
`define INS_MRET  32'h3020_0073

`define NUM_REGS 32

`endif

/* hw/decode_pkg.sv */
package decode_pkg;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////

    // data word, also used for addresses
    typedef logic [31:0] word_t;

    // register index, x0..x31
    typedef logic [4:0] reg_addr_t;

    ////////////////////////////////////////
    // control field widths
    ////////////////////////////////////////

    // alu operation, codes in decode_consts.svh
    typedef logic [2:0] alu_sel_t;

    // load/store size and sign
    // same encoding as funct3 of the memory op
    typedef logic [2:0] mem_ctrl_t;

    ////////////////////////////////////////
    // trap sequencing
    ////////////////////////////////////////

    // idle   : normal execution
    // active : inside the trap handler, until mret
    typedef enum logic {
        trap_idle   = 1'b0,
        trap_active = 1'b1
    } trap_state_t;

endpackage

/* hw/reg_file.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module reg_file import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     wd,
    input  logic      we,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    // architectural registers
    // entry 0 exists but only ever holds the reset value
    word_t regs [`NUM_REGS];

    ////////////////////////////////////////
    // write port, from writeback
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;
        end
    end

    ////////////////////////////////////////
    // read ports with write-through
    ////////////////////////////////////////

    // x0 hardwired, then same-cycle writeback, then array
    always_comb begin
        if (rs1 == '0)
            rs1_data = '0;
        else if (we && (rd == rs1))
            rs1_data = wd;
        else
            rs1_data = regs[rs1];

        if (rs2 == '0)
            rs2_data = '0;
        else if (we && (rd == rs2))
            rs2_data = wd;
        else
            rs2_data = regs[rs2];
    end

    // x0 storage must stay zero across any writeback sequence
    a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("reg_file: x0 storage was overwritten");

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module imm_gen import decode_pkg::*; (
    input  word_t ins,
    output word_t imm
);

    logic [6:0] opcode;

    assign opcode = ins[6:0];

    ////////////////////////////////////////
    // format select by opcode
    ////////////////////////////////////////

    // sign bit is always ins[31]
    always_comb begin
        case (opcode)
            // i-type: arith imm, loads, jalr
            `OPC_OPIMM, `OPC_LOAD, `OPC_JALR: begin
                imm = {{20{ins[31]}}, ins[31:20]};
            end
            // s-type, imm split around rd field
            `OPC_STORE: begin
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            // b-type, halfword offset
            `OPC_BRANCH: begin
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            // u-type
            // upper 20 bits, low 12 zero
            `OPC_LUI, `OPC_AUIPC: begin
                imm = {ins[31:12], 12'b0};
            end
            // j-type, halfword offset
            `OPC_JAL: begin
                imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            // r-type, system and anything unknown
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* hw/ctrl_decode.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module ctrl_decode import decode_pkg::*; (
    input  word_t     ins,
    output alu_sel_t  alusel,
    output logic      alusrc,
    output logic      memread,
    output logic      memwrite,
    output logic      regwrite,
    output mem_ctrl_t mem_ctrl,
    output logic      jal,
    output logic      jalr,
    output logic      is_branch,
    output logic      lui,
    output logic      auipc,
    output logic      ecall,
    output logic      mret
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];
    assign funct7 = ins[31:25];

    // funct3 to alu op
    // sltu folds into slt and sra into srl
    function automatic alu_sel_t f3_to_alu(input logic [2:0] f3, input logic sub);
        alu_sel_t sel;
        case (f3)
            3'b000:  sel = sub ? `ALU_SUB : `ALU_ADD;
            3'b001:  sel = `ALU_SLL;
            3'b010:  sel = `ALU_SLT;
            3'b011:  sel = `ALU_SLT;
            3'b100:  sel = `ALU_XOR;
            3'b101:  sel = `ALU_SRL;
            3'b110:  sel = `ALU_OR;
            default: sel = `ALU_AND;
        endcase
        return sel;
    endfunction

    ////////////////////////////////////////
    // main decode
    ////////////////////////////////////////

    always_comb begin
        // everything off unless the opcode enables it
        alusel    = `ALU_ADD;
        alusrc    = 1'b0;
        memread   = 1'b0;
        memwrite  = 1'b0;
        regwrite  = 1'b0;
        mem_ctrl  = '0;
        jal       = 1'b0;
        jalr      = 1'b0;
        is_branch = 1'b0;
        lui       = 1'b0;
        auipc     = 1'b0;
        case (opcode)
            `OPC_LUI:   begin regwrite = 1'b1; alusrc = 1'b1; lui = 1'b1; end
            `OPC_AUIPC: begin regwrite = 1'b1; alusrc = 1'b1; auipc = 1'b1; end
            `OPC_JAL:   begin regwrite = 1'b1; jal = 1'b1; end
            `OPC_JALR:  begin regwrite = 1'b1; jalr = 1'b1; end
            // compare happens in branch_unit, alu only sees a sub
            `OPC_BRANCH: begin is_branch = 1'b1; alusel = `ALU_SUB; end
            `OPC_LOAD: begin
                memread  = 1'b1;
                regwrite = 1'b1;
                alusrc   = 1'b1;
                mem_ctrl = funct3;
            end
            `OPC_STORE: begin
                memwrite = 1'b1;
                alusrc   = 1'b1;
                mem_ctrl = funct3;
            end
            // no subtract form for immediates
            `OPC_OPIMM: begin regwrite = 1'b1; alusrc = 1'b1; alusel = f3_to_alu(funct3, 1'b0); end
            `OPC_OP:    begin regwrite = 1'b1; alusel = f3_to_alu(funct3, funct7[5]); end
            default: ;
        endcase
    end

    // system words matched whole, other system encodings ignored
    assign ecall = (ins == `INS_ECALL);
    assign mret  = (ins == `INS_MRET);

    // one opcode never both loads and stores
    always_comb begin
        a_mem_excl: assert final (!(memread && memwrite))
            else $error("ctrl_decode: memread and memwrite both set");
    end

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit import decode_pkg::*; (
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      uses_rs2,
    input  logic      is_branch,
    input  reg_addr_t id_ex_rd,
    input  logic      id_ex_memread,
    input  logic      id_ex_regwrite,
    input  reg_addr_t ex_mem_rd,
    input  logic      ex_mem_memread,
    output logic      hz
);

    // source matches against the instruction in execute
    logic ex_hit;
    // source matches against the instruction in memory
    logic mem_hit;
    logic load_use;
    logic br_ex;
    logic br_mem;

    // x0 never creates a dependency
    assign ex_hit  = (id_ex_rd != '0) &&
                     ((id_ex_rd == rs1) || (uses_rs2 && (id_ex_rd == rs2)));
    assign mem_hit = (ex_mem_rd != '0) &&
                     ((ex_mem_rd == rs1) || (uses_rs2 && (ex_mem_rd == rs2)));

    ////////////////////////////////////////
    // stall sources
    ////////////////////////////////////////

    // load in execute, data not ready until after mem
    assign load_use = id_ex_memread && ex_hit;

    // branch/jalr resolves here
    // any result still in execute is too late
    assign br_ex = is_branch && id_ex_regwrite && ex_hit;

    // alu results in ex/mem are forwarded, loaded data is not
    assign br_mem = is_branch && ex_mem_memread && mem_hit;

    assign hz = load_use || br_ex || br_mem;

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module branch_unit import decode_pkg::*; (
    input  word_t     ins,
    input  word_t     pres_addr,
    input  word_t     imm,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  logic      is_branch,
    input  logic      jal,
    input  logic      jalr,
    input  reg_addr_t ex_mem_rd,
    input  logic      ex_mem_regwrite,
    input  word_t     ex_mem_alures,
    input  logic      hz,
    output logic      branch,
    output word_t     branoff
);

    reg_addr_t src1;
    reg_addr_t src2;
    word_t     op1;
    word_t     op2;
    logic      cond;
    word_t     jalr_sum;

    assign src1 = ins[19:15];
    assign src2 = ins[24:20];

    ////////////////////////////////////////
    // operand forwarding from ex/mem
    ////////////////////////////////////////

    assign op1 = (ex_mem_regwrite && (ex_mem_rd != '0) && (ex_mem_rd == src1)) ?
                 ex_mem_alures : rs1_data;
    assign op2 = (ex_mem_regwrite && (ex_mem_rd != '0) && (ex_mem_rd == src2)) ?
                 ex_mem_alures : rs2_data;

    // condition by funct3
    always_comb begin
        case (ins[14:12])
            `F3_BEQ:  cond = (op1 == op2);
            `F3_BNE:  cond = (op1 != op2);
            `F3_BLT:  cond = ($signed(op1) < $signed(op2));
            `F3_BGE:  cond = ($signed(op1) >= $signed(op2));
            `F3_BLTU: cond = (op1 < op2);
            `F3_BGEU: cond = (op1 >= op2);
            default:  cond = 1'b0;
        endcase
    end

    // redirect, never while operands are stale
    assign branch = ((is_branch && cond) || jal || jalr) && !hz;

    // jalr target drops bit 0
    assign jalr_sum = op1 + imm;
    assign branoff  = jalr ? {jalr_sum[31:1], 1'b0} : (pres_addr + imm);

endmodule

/* hw/trap_ctrl.sv */
`timescale 1ns/1ns

module trap_ctrl import decode_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ecall,
    input  logic mret,
    input  logic hold,
    output logic trapping,
    output logic trigger_trap,
    output logic trigger_trap_ret
);

    trap_state_t state;

    // pulses last one cycle, state moves only when not held
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= trap_idle;
            trigger_trap     <= 1'b0;
            trigger_trap_ret <= 1'b0;
        end else begin
            trigger_trap     <= 1'b0;
            trigger_trap_ret <= 1'b0;
            if (!hold) begin
                case (state)
                    // enter handler
                    trap_idle: if (ecall) begin
                        state        <= trap_active;
                        trigger_trap <= 1'b1;
                    end
                    // nested ecall ignored, only mret leaves
                    trap_active: if (mret) begin
                        state            <= trap_idle;
                        trigger_trap_ret <= 1'b1;
                    end
                    default: state <= trap_idle;
                endcase
            end
        end
    end

    assign trapping = (state == trap_active);

    a_trig_excl: assert property (@(posedge clk) disable iff (rst)
        !(trigger_trap && trigger_trap_ret))
        else $error("trap_ctrl: entry and return pulses together");

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     ins,
    input  word_t     pres_addr,
    input  logic      mem_hold,
    input  reg_addr_t wb_rd,
    input  word_t     wb_res,
    input  logic      wb_regwrite,
    input  reg_addr_t ex_mem_rd,
    input  logic      ex_mem_regwrite,
    input  logic      ex_mem_memread,
    input  word_t     ex_mem_alures,
    output logic      hz,
    output logic      branch,
    output word_t     branoff,
    output word_t     id_ex_pres_addr,
    output reg_addr_t id_ex_rs1,
    output reg_addr_t id_ex_rs2,
    output reg_addr_t id_ex_rd,
    output word_t     id_ex_dout_rs1,
    output word_t     id_ex_dout_rs2,
    output word_t     id_ex_imm,
    output alu_sel_t  id_ex_alusel,
    output logic      id_ex_alusrc,
    output logic      id_ex_memread,
    output logic      id_ex_memwrite,
    output logic      id_ex_regwrite,
    output mem_ctrl_t id_ex_mem_ctrl,
    output logic      id_ex_jal,
    output logic      id_ex_lui,
    output logic      id_ex_auipc,
    output logic      trapping,
    output logic      trigger_trap,
    output logic      trigger_trap_ret
);

    word_t     rs1_data, rs2_data, imm;
    alu_sel_t  alusel;
    mem_ctrl_t mem_ctrl;
    logic      alusrc, memread, memwrite, regwrite;
    logic      jal, jalr, is_branch, lui, auipc, ecall, trap_ret;
    logic      uses_rs2, resolve_id;

    // rs2 read by r-type, stores and branches only
    assign uses_rs2   = is_branch || memwrite || (ins[6:0] == `OPC_OP);
    // these need their operands in this stage
    assign resolve_id = is_branch || jalr;

    reg_file u_reg_file (.clk(clk), .rst(rst), .rs1(ins[19:15]), .rs2(ins[24:20]),
        .rd(wb_rd), .wd(wb_res), .we(wb_regwrite),
        .rs1_data(rs1_data), .rs2_data(rs2_data));

    imm_gen u_imm_gen (.ins(ins), .imm(imm));

    ctrl_decode u_ctrl_decode (.ins(ins), .alusel(alusel), .alusrc(alusrc),
        .memread(memread), .memwrite(memwrite), .regwrite(regwrite), .mem_ctrl(mem_ctrl),
        .jal(jal), .jalr(jalr), .is_branch(is_branch), .lui(lui), .auipc(auipc),
        .ecall(ecall), .mret(trap_ret));

    hazard_unit u_hazard_unit (.rs1(ins[19:15]), .rs2(ins[24:20]), .uses_rs2(uses_rs2),
        .is_branch(resolve_id), .id_ex_rd(id_ex_rd), .id_ex_memread(id_ex_memread),
        .id_ex_regwrite(id_ex_regwrite), .ex_mem_rd(ex_mem_rd),
        .ex_mem_memread(ex_mem_memread), .hz(hz));

    branch_unit u_branch_unit (.ins(ins), .pres_addr(pres_addr), .imm(imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .is_branch(is_branch), .jal(jal),
        .jalr(jalr), .ex_mem_rd(ex_mem_rd), .ex_mem_regwrite(ex_mem_regwrite),
        .ex_mem_alures(ex_mem_alures), .hz(hz), .branch(branch), .branoff(branoff));

    trap_ctrl u_trap_ctrl (.clk(clk), .rst(rst), .ecall(ecall), .mret(trap_ret),
        .hold(mem_hold), .trapping(trapping), .trigger_trap(trigger_trap),
        .trigger_trap_ret(trigger_trap_ret));

    ////////////////////////////////////////
    // id/ex register
    ////////////////////////////////////////

    // controls: cleared on reset, bubble on hz, frozen on mem_hold
    always_ff @(posedge clk) begin
        if (rst || (!mem_hold && hz)) begin
            {id_ex_alusrc, id_ex_memread, id_ex_memwrite} <= '0;
            {id_ex_regwrite, id_ex_jal, id_ex_lui, id_ex_auipc} <= '0;
        end else if (!mem_hold) begin
            id_ex_alusrc   <= alusrc;
            id_ex_memread  <= memread;
            id_ex_memwrite <= memwrite;
            id_ex_regwrite <= regwrite;
            // jalr also writes pc+4, execute treats both alike
            id_ex_jal      <= jal || jalr;
            id_ex_lui      <= lui;
            id_ex_auipc    <= auipc;
        end
    end

    // payload, only meaningful under valid controls
    always_ff @(posedge clk) begin
        if (!mem_hold) begin
            id_ex_pres_addr <= pres_addr;
            id_ex_rs1       <= ins[19:15];
            id_ex_rs2       <= ins[24:20];
            id_ex_rd        <= ins[11:7];
            id_ex_dout_rs1  <= rs1_data;
            id_ex_dout_rs2  <= rs2_data;
            id_ex_imm       <= imm;
            id_ex_alusel    <= alusel;
            id_ex_mem_ctrl  <= mem_ctrl;
        end
    end

endmodule

/* sim/decode_tb.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module decode_tb import decode_pkg::*; ();

    localparam int    MAX_CYCLES = 400;
    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    logic      clk, rst, mem_hold;
    word_t     ins, pres_addr, wb_res, ex_mem_alures;
    reg_addr_t wb_rd, ex_mem_rd;
    logic      wb_regwrite, ex_mem_regwrite, ex_mem_memread;
    logic      hz, branch;
    word_t     branoff, id_ex_pres_addr, id_ex_dout_rs1, id_ex_dout_rs2, id_ex_imm;
    reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd;
    alu_sel_t  id_ex_alusel;
    mem_ctrl_t id_ex_mem_ctrl;
    logic      id_ex_alusrc, id_ex_memread, id_ex_memwrite, id_ex_regwrite;
    logic      id_ex_jal, id_ex_lui, id_ex_auipc;
    logic      trapping, trigger_trap, trigger_trap_ret;

    int    errors = 0;
    int    tests = 0;
    int    cycles = 0;
    int    seed = 62822;
    // shadow of the register file contents
    word_t regval [32];

    decode_stage decode_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit, well above the ~110 cycles of the directed sequence
    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////

    function automatic word_t enc_i(input word_t imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input word_t imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    // offset bit 0 is implied
    function automatic word_t enc_b(input word_t imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input word_t imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // ends 1 ns after the edge, where new inputs go
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive(input word_t i, input word_t pc);
        ins       = i;
        pres_addr = pc;
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        errors++;
    endtask

    // stand-in writeback, one register per cycle
    task automatic write_reg(input reg_addr_t rd, input word_t val);
        wb_rd       = rd;
        wb_res      = val;
        wb_regwrite = 1'b1;
        drive(NOP, 32'h0);
        next_cycle();
        wb_regwrite = 1'b0;
        regval[rd]  = val;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        tests++;
        if ({id_ex_alusrc, id_ex_memread, id_ex_memwrite, id_ex_regwrite} !== 4'b0)
            report_mismatch("id_ex_{alusrc,memread,memwrite,regwrite}",
                            {id_ex_alusrc, id_ex_memread, id_ex_memwrite, id_ex_regwrite}, 0);
        if ({id_ex_jal, id_ex_lui, id_ex_auipc} !== 3'b0)
            report_mismatch("id_ex_{jal,lui,auipc}", {id_ex_jal, id_ex_lui, id_ex_auipc}, 0);
        if (trapping !== 1'b0)
            report_mismatch("trapping", trapping, 0);
    endtask

    task automatic test_regs();
        word_t nv;
        tests++;
        for (int i = 1; i < 32; i++) begin
            write_reg(i, $random(seed));
        end
        // rs1 walks up, rs2 walks down, both hit x0 once
        // rd offset from rs1 so swapped fields show
        for (int i = 0; i < 32; i++) begin
            drive(enc_r(7'h00, 31 - i, i, 3'b000, (i + 7) % 32), 32'h0);
            next_cycle();
            if (id_ex_dout_rs1 !== regval[i])
                report_mismatch("id_ex_dout_rs1", id_ex_dout_rs1, regval[i]);
            if (id_ex_dout_rs2 !== regval[31 - i])
                report_mismatch("id_ex_dout_rs2", id_ex_dout_rs2, regval[31 - i]);
            if (id_ex_rs1 !== i)
                report_mismatch("id_ex_rs1", id_ex_rs1, i);
            if (id_ex_rs2 !== 31 - i)
                report_mismatch("id_ex_rs2", id_ex_rs2, 31 - i);
            if (id_ex_rd !== (i + 7) % 32)
                report_mismatch("id_ex_rd", id_ex_rd, (i + 7) % 32);
        end
        // writeback and read of x9 in the same cycle
        nv          = $random(seed);
        wb_rd       = 9;
        wb_res      = nv;
        wb_regwrite = 1'b1;
        drive(enc_r(7'h00, 9, 9, 3'b000, 0), 32'h0);
        next_cycle();
        wb_regwrite = 1'b0;
        regval[9]   = nv;
        if (id_ex_dout_rs1 !== nv)
            report_mismatch("id_ex_dout_rs1", id_ex_dout_rs1, nv);
        if (id_ex_dout_rs2 !== nv)
            report_mismatch("id_ex_dout_rs2", id_ex_dout_rs2, nv);
    endtask

    task automatic check_imm(input word_t i, input word_t exp);
        drive(i, 32'h0);
        next_cycle();
        if (id_ex_imm !== exp)
            report_mismatch("id_ex_imm", id_ex_imm, exp);
    endtask

    task automatic test_imm();
        tests++;
        // all sources x0, so no hazard can fire
        check_imm(enc_i(32'hFFFF_FFFB, 0, 3'b000, 0, `OPC_OPIMM), 32'hFFFF_FFFB);
        check_imm(enc_i(32'h0000_07FF, 0, 3'b010, 1, `OPC_LOAD), 32'h0000_07FF);
        check_imm(enc_i(32'hFFFF_F800, 0, 3'b000, 0, `OPC_JALR), 32'hFFFF_F800);
        check_imm(enc_s(32'hFFFF_F800, 0, 0, 3'b010), 32'hFFFF_F800);
        check_imm(enc_b(32'hFFFF_FFF0, 0, 0, `F3_BEQ), 32'hFFFF_FFF0);
        check_imm(enc_b(32'h0000_0FFE, 0, 0, `F3_BNE), 32'h0000_0FFE);
        check_imm({20'hABCDE, 5'd0, `OPC_LUI}, 32'hABCD_E000);
        check_imm(enc_j(32'h000F_F00A, 0), 32'h000F_F00A);
        check_imm(enc_j(32'hFFF0_0A02, 0), 32'hFFF0_0A02);
    endtask

    task automatic check_ctrl(input word_t i, input alu_sel_t sel, input logic mr,
                              input logic mw, input logic rw, input mem_ctrl_t mc,
                              input logic lu, input logic au);
        drive(i, 32'h0);
        next_cycle();
        if (id_ex_alusel !== sel)   report_mismatch("id_ex_alusel", id_ex_alusel, sel);
        if (id_ex_memread !== mr)   report_mismatch("id_ex_memread", id_ex_memread, mr);
        if (id_ex_memwrite !== mw)  report_mismatch("id_ex_memwrite", id_ex_memwrite, mw);
        if (id_ex_regwrite !== rw)  report_mismatch("id_ex_regwrite", id_ex_regwrite, rw);
        if (id_ex_mem_ctrl !== mc)  report_mismatch("id_ex_mem_ctrl", id_ex_mem_ctrl, mc);
        if (id_ex_lui !== lu)       report_mismatch("id_ex_lui", id_ex_lui, lu);
        if (id_ex_auipc !== au)     report_mismatch("id_ex_auipc", id_ex_auipc, au);
    endtask

    task automatic test_ctrl();
        tests++;
        // loads write x3, nothing after them reads x3
        check_ctrl(enc_i(8, 2, 3'b010, 3, `OPC_LOAD), `ALU_ADD, 1, 0, 1, 3'b010, 0, 0);
        check_ctrl(enc_i(1, 2, 3'b100, 3, `OPC_LOAD), `ALU_ADD, 1, 0, 1, 3'b100, 0, 0);
        check_ctrl(enc_s(32'hFFFF_FFFC, 4, 2, 3'b010), `ALU_ADD, 0, 1, 0, 3'b010, 0, 0);
        check_ctrl(enc_s(5, 4, 2, 3'b000), `ALU_ADD, 0, 1, 0, 3'b000, 0, 0);
        check_ctrl(enc_r(7'h00, 4, 2, 3'b000, 1), `ALU_ADD, 0, 0, 1, 3'b000, 0, 0);
        check_ctrl(enc_r(7'h20, 4, 2, 3'b000, 1), `ALU_SUB, 0, 0, 1, 3'b000, 0, 0);
        check_ctrl({20'h12345, 5'd3, `OPC_LUI}, `ALU_ADD, 0, 0, 1, 3'b000, 1, 0);
        check_ctrl({20'h12345, 5'd3, `OPC_AUIPC}, `ALU_ADD, 0, 0, 1, 3'b000, 0, 1);
    endtask

    task automatic test_stall_hold();
        tests++;
        // lw x5 then add x6, x5, x0
        drive(enc_i(0, 0, 3'b010, 5, `OPC_LOAD), 32'h0);
        next_cycle();
        drive(enc_r(7'h00, 0, 5, 3'b000, 6), 32'h4);
        #1;
        if (hz !== 1'b1)
            report_mismatch("hz", hz, 1);
        next_cycle();
        if ({id_ex_memread, id_ex_memwrite, id_ex_regwrite, id_ex_jal} !== 4'b0)
            report_mismatch("id_ex_{memread,memwrite,regwrite,jal}",
                            {id_ex_memread, id_ex_memwrite, id_ex_regwrite, id_ex_jal}, 0);
        // bubble in execute, add goes through now
        if (hz !== 1'b0)
            report_mismatch("hz", hz, 0);
        next_cycle();
        if (id_ex_regwrite !== 1'b1)
            report_mismatch("id_ex_regwrite", id_ex_regwrite, 1);
        // addi x7 captured, then frozen under mem_hold
        drive(enc_i(32'h55, 0, 3'b000, 7, `OPC_OPIMM), 32'h100);
        next_cycle();
        mem_hold = 1'b1;
        drive(enc_s(32'h10, 0, 0, 3'b010), 32'h200);
        next_cycle();
        next_cycle();
        if (id_ex_imm !== 32'h55)        report_mismatch("id_ex_imm", id_ex_imm, 32'h55);
        if (id_ex_pres_addr !== 32'h100) report_mismatch("id_ex_pres_addr", id_ex_pres_addr, 32'h100);
        if (id_ex_regwrite !== 1'b1)     report_mismatch("id_ex_regwrite", id_ex_regwrite, 1);
        if (id_ex_memwrite !== 1'b0)     report_mismatch("id_ex_memwrite", id_ex_memwrite, 0);
        if (id_ex_alusrc !== 1'b1)       report_mismatch("id_ex_alusrc", id_ex_alusrc, 1);
        mem_hold = 1'b0;
        next_cycle();
        if (id_ex_pres_addr !== 32'h200) report_mismatch("id_ex_pres_addr", id_ex_pres_addr, 32'h200);
        if (id_ex_memwrite !== 1'b1)     report_mismatch("id_ex_memwrite", id_ex_memwrite, 1);
    endtask

    // decision and target are combinational, sampled mid cycle
    task automatic check_branch(input word_t i, input word_t pc, input logic exp_br,
                                input word_t exp_off);
        drive(i, pc);
        #1;
        if (branch !== exp_br)
            report_mismatch("branch", branch, exp_br);
        if (branoff !== exp_off)
            report_mismatch("branoff", branoff, exp_off);
        next_cycle();
    endtask

    task automatic test_branch();
        tests++;
        write_reg(10, 32'h1234);
        write_reg(11, 32'h1234);
        write_reg(12, 32'h9999);
        write_reg(13, 32'hDEAD);
        check_branch(enc_b(8, 11, 10, `F3_BEQ), 32'h400, 1, 32'h400 + 32'h8);
        check_branch(enc_b(8, 11, 10, `F3_BNE), 32'h400, 0, 32'h400 + 32'h8);
        check_branch(enc_b(32'hFFFF_FFE0, 12, 10, `F3_BNE), 32'h400, 1, 32'h400 - 32'h20);
        check_branch(enc_b(32'hFFFF_FFE0, 12, 10, `F3_BEQ), 32'h400, 0, 32'h400 - 32'h20);
        // x13 holds dead, ex/mem result for x13 is 1234
        ex_mem_rd       = 13;
        ex_mem_alures   = 32'h1234;
        ex_mem_regwrite = 1'b1;
        check_branch(enc_b(16, 13, 10, `F3_BEQ), 32'h500, 1, 32'h500 + 32'h10);
        ex_mem_regwrite = 1'b0;
        check_branch(enc_b(16, 13, 10, `F3_BEQ), 32'h500, 0, 32'h500 + 32'h10);
        // jalr x1, 0x11(x10), odd sum
        check_branch(enc_i(32'h11, 10, 3'b000, 1, `OPC_JALR), 32'h600, 1,
                     (32'h1234 + 32'h11) & ~32'h1);
        // jalr now in execute as a link write
        if (id_ex_jal !== 1'b1)
            report_mismatch("id_ex_jal", id_ex_jal, 1);
        drive(NOP, 32'h0);
        next_cycle();
    endtask

    task automatic test_trap();
        tests++;
        drive(`INS_ECALL, 32'h700);
        next_cycle();
        if (trigger_trap !== 1'b1) report_mismatch("trigger_trap", trigger_trap, 1);
        if (trapping !== 1'b1)     report_mismatch("trapping", trapping, 1);
        drive(NOP, 32'h704);
        next_cycle();
        if (trigger_trap !== 1'b0) report_mismatch("trigger_trap", trigger_trap, 0);
        // nested ecall, handler already running
        drive(`INS_ECALL, 32'h708);
        next_cycle();
        if (trigger_trap !== 1'b0) report_mismatch("trigger_trap", trigger_trap, 0);
        if (trapping !== 1'b1)     report_mismatch("trapping", trapping, 1);
        drive(`INS_MRET, 32'h70C);
        next_cycle();
        if (trigger_trap_ret !== 1'b1) report_mismatch("trigger_trap_ret", trigger_trap_ret, 1);
        if (trapping !== 1'b0)         report_mismatch("trapping", trapping, 0);
        drive(NOP, 32'h710);
        next_cycle();
        if (trigger_trap_ret !== 1'b0) report_mismatch("trigger_trap_ret", trigger_trap_ret, 0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst             = 1'b1;
        mem_hold        = 1'b0;
        ins             = NOP;
        pres_addr       = '0;
        wb_rd           = '0;
        wb_res          = '0;
        wb_regwrite     = 1'b0;
        ex_mem_rd       = '0;
        ex_mem_regwrite = 1'b0;
        ex_mem_memread  = 1'b0;
        ex_mem_alures   = '0;
        for (int i = 0; i < 32; i++) begin
            regval[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_regs();
        test_imm();
        test_ctrl();
        test_stall_hold();
        test_branch();
        test_trap();
        $display("decode_tb: %0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/decode_pkg.sv
hw/reg_file.sv
hw/imm_gen.sv
hw/ctrl_decode.sv
hw/hazard_unit.sv
hw/branch_unit.sv
hw/trap_ctrl.sv
hw/decode_stage.sv
sim/decode_tb.sv
